//--- compile.f
+incdir+sim
hdl/tlp_pkg.sv
hdl/tlp_req_if.sv
hdl/tlp_cmd_sequencer.sv
hdl/tlp_hdr_formatter.sv
hdl/tlp_hdr_gen_top.sv
sim/tb_checker.sv
sim/tb_top.sv

//--- run.sh
#!/bin/sh
# Build and run the header generator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -f compile.f --top-module tb_top -o sim_tb
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "TEST PASS"; then
  exit 0
fi
exit 1

//--- sim/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Each row holds kind, wr, addr, len, bus, dev, func, reg, tag in, stall kind (0 none,
// 1 hdr_ready low, 2 posted credit low), header expected, tag consume expected and the
// expected header from byte 15 down to byte 0
// All expected headers assume requester ID 16'hABCD

typedef struct packed {
  cmd_kind_e          kind;
  logic               wr;
  logic [63:0]        addr;
  logic [9:0]         len;
  logic [7:0]         bus;
  logic [4:0]         dev;
  logic [2:0]         func;
  logic [9:0]         reg_num;
  logic [7:0]         tag;
  logic [1:0]         stall;
  logic               has_hdr;
  logic               consume;
  logic [127:0]       hdr;
} vec_t;

localparam int NUM_ROWS = 10;

localparam vec_t VECS [0:NUM_ROWS-1] = '{
  '{CMD_MEM, 1'b0, 64'h0000_0000_1234_5678, 10'd4, 8'h00, 5'h00, 3'h0, 10'h000, 8'h11, 2'd0,
    1'b1, 1'b1, 128'h00000000_78563412_FF11CDAB_04000000},
  '{CMD_MEM, 1'b0, 64'h0000_0001_8000_0002, 10'd1, 8'h00, 5'h00, 3'h0, 10'h000, 8'h22, 2'd0,
    1'b1, 1'b1, 128'h00000080_01000000_3C22CDAB_01000020},
  '{CMD_MEM, 1'b1, 64'h0000_0000_0000_1001, 10'd2, 8'h00, 5'h00, 3'h0, 10'h000, 8'h33, 2'd0,
    1'b1, 1'b0, 128'h00000000_00100000_1E00CDAB_02000040},
  '{CMD_MEM, 1'b1, 64'hFEDC_BA98_7654_3213, 10'h3FF, 8'h00, 5'h00, 3'h0, 10'h000, 8'h3A, 2'd0,
    1'b1, 1'b0, 128'h10325476_98BADCFE_7800CDAB_FF030060},
  '{CMD_CFG, 1'b0, 64'h0, 10'd7, 8'h5A, 5'h1F, 3'h5, 10'h2A7, 8'h44, 2'd0,
    1'b1, 1'b1, 128'h00000000_9C0AFD5A_0F44CDAB_01000004},
  '{CMD_CFG, 1'b1, 64'h0, 10'd3, 8'h01, 5'h02, 3'h3, 10'h004, 8'h55, 2'd0,
    1'b1, 1'b1, 128'h00000000_10001301_0F55CDAB_01000044},
  '{CMD_IO,  1'b0, 64'h0000_0000_0000_0100, 10'd1, 8'h00, 5'h00, 3'h0, 10'h000, 8'h5B, 2'd0,
    1'b0, 1'b0, 128'h0},
  '{CMD_MSG, 1'b1, 64'h0000_0000_0000_0200, 10'd1, 8'h00, 5'h00, 3'h0, 10'h000, 8'h5C, 2'd0,
    1'b0, 1'b0, 128'h0},
  '{CMD_MEM, 1'b0, 64'h0000_0000_0000_00FC, 10'd1, 8'h00, 5'h00, 3'h0, 10'h000, 8'h66, 2'd1,
    1'b1, 1'b1, 128'h00000000_FC000000_FF66CDAB_01000000},
  '{CMD_MEM, 1'b1, 64'h0000_0000_0000_2000, 10'd1, 8'h00, 5'h00, 3'h0, 10'h000, 8'h77, 2'd2,
    1'b1, 1'b0, 128'h00000000_00200000_FF00CDAB_01000040}
};

`endif

//--- sim/tb_top.sv
`timescale 1ns/1ps

module tb_top
  import tlp_pkg::*;
();

  `include "tb_vectors.svh"

  localparam int TIMEOUT = 200;              // Cycles per wait

  logic              clk = 1'b0;
  logic              rst_n;
  logic              cmd_valid_i;
  cmd_kind_e         cmd_kind_i;
  logic              cmd_wr_i;
  logic [63:0]       cmd_addr_i;
  logic [9:0]        cmd_len_i;
  logic [7:0]        cmd_bus_i;
  logic [4:0]        cmd_dev_i;
  logic [2:0]        cmd_func_i;
  logic [9:0]        cmd_reg_i;
  logic              cmd_ready_o;
  logic [15:0]       requester_id_i;
  logic [7:0]        tag_i;
  logic              tag_valid_i;
  logic              tag_consume_o;
  logic              ph_credit_ok_i;
  logic              pd_credit_ok_i;
  logic              nph_credit_ok_i;
  logic              npd_credit_ok_i;
  logic [127:0]      hdr_o;
  logic              hdr_valid_o;
  logic              hdr_ready_i;
  logic [1:0]        stall_kind = 2'd0;      // Back-pressure source for the row
  logic              consume_seen = 1'b0;
  logic              idle_seen = 1'b1;
  int                tag_delay = 0;
  logic              aborted = 1'b0;

  always #10 clk = ~clk;

  tlp_hdr_gen_top tlp_hdr_gen_top_i (.*);

  tb_checker checker_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .hdr_i         (hdr_o),
    .hdr_valid_i   (hdr_valid_o),
    .tag_consume_i (tag_consume_o),
    .hold_i        (stall_kind != 2'd0)
  );

  // Tag table model presents a tag a few cycles after a command leaves idle
  always @(negedge clk) begin
    consume_seen = tag_consume_o;
    idle_seen = cmd_ready_o;
  end

  always @(posedge clk) begin
    #1;
    if (consume_seen || idle_seen) begin
      tag_valid_i = 1'b0;
      tag_delay = $urandom_range(1, 4);
    end else if (tag_delay > 0) begin
      tag_delay--;
    end else begin
      tag_valid_i = 1'b1;
    end
  end

  // Credit and ready model keeps each level mostly high
  always @(posedge clk) begin
    #1;
    ph_credit_ok_i  = ($urandom_range(0, 3) != 0) && (stall_kind != 2'd2);
    pd_credit_ok_i  = ($urandom_range(0, 3) != 0);
    nph_credit_ok_i = ($urandom_range(0, 3) != 0);
    npd_credit_ok_i = ($urandom_range(0, 3) != 0);
    hdr_ready_i     = ($urandom_range(0, 3) != 0) && (stall_kind != 2'd1);
  end

  task automatic wait_idle(output logic ok);
    int n;
    n = 0;
    while (!cmd_ready_o && n < TIMEOUT) begin
      @(posedge clk);
      #1;
      n++;
    end
    ok = cmd_ready_o;
  endtask

  task automatic wait_done(input int target, output logic ok);
    int n;
    n = 0;
    while (!(cmd_ready_o && checker_i.hdr_seen >= target) && n < TIMEOUT) begin
      @(posedge clk);
      #1;
      n++;
    end
    ok = cmd_ready_o && (checker_i.hdr_seen >= target);
  endtask

  task automatic run_row(input int idx);
    vec_t  row;
    logic  ok;
    int    target;
    row = VECS[idx];
    stall_kind = row.stall;
    checker_i.start_row(row.hdr, row.has_hdr);
    target = checker_i.hdr_seen + int'(row.has_hdr);
    wait_idle(ok);
    if (!ok) begin
      $display("Timeout: cmd_ready_o never rose before row %0d", idx);
      aborted = 1'b1;
      return;
    end
    cmd_kind_i  = row.kind;
    cmd_wr_i    = row.wr;
    cmd_addr_i  = row.addr;
    cmd_len_i   = row.len;
    cmd_bus_i   = row.bus;
    cmd_dev_i   = row.dev;
    cmd_func_i  = row.func;
    cmd_reg_i   = row.reg_num;
    tag_i       = row.tag;
    cmd_valid_i = 1'b1;
    @(posedge clk);
    #1;
    cmd_valid_i = 1'b0;
    if (row.stall != 2'd0) begin
      repeat ($urandom_range(12, 24)) @(posedge clk);
      #1;
      stall_kind = 2'd0;                     // One header must follow the release
    end
    wait_done(target, ok);
    if (!ok) begin
      $display("Timeout: row %0d did not complete", idx);
      aborted = 1'b1;
      return;
    end
    checker_i.end_row(idx, row.consume);
  endtask

  initial begin
    void'($urandom(79));
    rst_n           = 1'b0;
    cmd_valid_i     = 1'b0;
    cmd_kind_i      = CMD_MEM;
    cmd_wr_i        = 1'b0;
    cmd_addr_i      = '0;
    cmd_len_i       = '0;
    cmd_bus_i       = '0;
    cmd_dev_i       = '0;
    cmd_func_i      = '0;
    cmd_reg_i       = '0;
    requester_id_i  = 16'hABCD;
    tag_i           = '0;
    tag_valid_i     = 1'b0;
    ph_credit_ok_i  = 1'b0;
    pd_credit_ok_i  = 1'b0;
    nph_credit_ok_i = 1'b0;
    npd_credit_ok_i = 1'b0;
    hdr_ready_i     = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (int i = 0; i < NUM_ROWS && !aborted; i++) begin
      run_row(i);
    end
    repeat (5) @(posedge clk);
    checker_i.print_counts();
    if (!aborted && checker_i.err_cnt == 0 && checker_i.pass_cnt == NUM_ROWS) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- sim/tb_checker.sv
`timescale 1ns/1ps

module tb_checker
  import tlp_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic [HDR_W-1:0]  hdr_i,
  input  logic              hdr_valid_i,
  input  logic              tag_consume_i,
  input  logic              hold_i
);

  logic [HDR_W-1:0]  exp_q[$];
  logic              prev_valid = 1'b0;
  int                hdr_seen = 0;
  int                consume_cnt = 0;
  int                err_cnt = 0;
  int                row_errs = 0;
  int                pass_cnt = 0;
  int                fail_cnt = 0;

  task automatic value_error(input string name, input logic [HDR_W-1:0] got,
                             input logic [HDR_W-1:0] exp);
    $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
    err_cnt++;
    row_errs++;
  endtask

  task automatic other_error(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    err_cnt++;
    row_errs++;
  endtask

  always @(posedge clk) begin
    if (rst_n) begin
      if (hdr_valid_i && prev_valid) begin
        other_error("hdr_valid_o stayed high for more than one cycle");
      end
      if (hdr_valid_i) begin
        hdr_seen++;
        if (hold_i) begin
          other_error("header emitted while back-pressure was held");
        end
        if (exp_q.size() == 0) begin
          other_error("header emitted with no header expected");
        end else if (hdr_i !== exp_q[0]) begin
          value_error("hdr_o", hdr_i, exp_q.pop_front());
        end else begin
          void'(exp_q.pop_front());
        end
      end
      if (tag_consume_i) begin
        consume_cnt++;
      end
      prev_valid = hdr_valid_i;
    end
  end

  task automatic start_row(input logic [HDR_W-1:0] hdr, input logic has_hdr);
    consume_cnt = 0;
    row_errs = 0;
    if (has_hdr) begin
      exp_q.push_back(hdr);
    end
  endtask

  task automatic end_row(input int idx, input logic consume);
    if (consume_cnt != int'(consume)) begin
      value_error("tag_consume_o pulses", HDR_W'(consume_cnt), HDR_W'(consume));
    end
    if (row_errs == 0) begin
      pass_cnt++;
      $display("Row %0d passed at %0t ns", idx, $time);
    end else begin
      fail_cnt++;
      $display("Row %0d failed with %0d errors", idx, row_errs);
    end
  endtask

  task automatic print_counts();
    if (exp_q.size() != 0) begin
      other_error("expected headers never appeared");
    end
    $display("Rows passed %0d, rows failed %0d, errors %0d", pass_cnt, fail_cnt, err_cnt);
  endtask

endmodule

//--- hdl/tlp_hdr_gen_top.sv
`timescale 1ns/1ps

module tlp_hdr_gen_top
  import tlp_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,

  input  logic                  cmd_valid_i,
  input  cmd_kind_e             cmd_kind_i,
  input  logic                  cmd_wr_i,
  input  logic [ADDR_W-1:0]     cmd_addr_i,
  input  logic [LEN_W-1:0]      cmd_len_i,
  input  logic [BUS_W-1:0]      cmd_bus_i,
  input  logic [DEV_W-1:0]      cmd_dev_i,
  input  logic [FUNC_W-1:0]     cmd_func_i,
  input  logic [CFG_REG_W-1:0]  cmd_reg_i,
  output logic                  cmd_ready_o,

  input  logic [RID_W-1:0]      requester_id_i,

  input  logic [TAG_W-1:0]      tag_i,
  input  logic                  tag_valid_i,
  output logic                  tag_consume_o,

  input  logic                  ph_credit_ok_i,
  input  logic                  pd_credit_ok_i,
  input  logic                  nph_credit_ok_i,
  input  logic                  npd_credit_ok_i,

  output logic [HDR_W-1:0]      hdr_o,
  output logic                  hdr_valid_o,
  input  logic                  hdr_ready_i
);

  tlp_cmd_t cmd;

  assign cmd = '{
    kind:    cmd_kind_i,
    wr:      cmd_wr_i,
    addr:    cmd_addr_i,
    len:     cmd_len_i,
    bus:     cmd_bus_i,
    dev:     cmd_dev_i,
    func:    cmd_func_i,
    reg_num: cmd_reg_i
  };

  tlp_req_if req_if ();

  tlp_cmd_sequencer u_seq (
    .clk             (clk),
    .rst_n           (rst_n),
    .cmd_i           (cmd),
    .cmd_valid_i     (cmd_valid_i),
    .cmd_ready_o     (cmd_ready_o),
    .tag_i           (tag_i),
    .tag_valid_i     (tag_valid_i),
    .tag_consume_o   (tag_consume_o),
    .ph_credit_ok_i  (ph_credit_ok_i),
    .pd_credit_ok_i  (pd_credit_ok_i),
    .nph_credit_ok_i (nph_credit_ok_i),
    .npd_credit_ok_i (npd_credit_ok_i),
    .hdr_ready_i     (hdr_ready_i),
    .req             (req_if.seq)
  );

  tlp_hdr_formatter u_fmt (
    .clk             (clk),
    .rst_n           (rst_n),
    .requester_id_i  (requester_id_i),
    .req             (req_if.fmt),
    .hdr_o           (hdr_o),
    .hdr_valid_o     (hdr_valid_o)
  );

endmodule

//--- hdl/tlp_hdr_formatter.sv
`timescale 1ns/1ps

module tlp_hdr_formatter
  import tlp_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,

  input  logic [RID_W-1:0]  requester_id_i,

  tlp_req_if.fmt            req,

  output logic [HDR_W-1:0]  hdr_o,
  output logic              hdr_valid_o
);

  tlp_cmd_t                      cmd;
  logic                          is_cfg;
  logic                          is_64;
  fmt_type_e                     opcode;
  logic [LEN_W-1:0]              len_dw;
  logic [7:0]                    be;
  logic [ADDR_W-1:0]             addr_dw;
  logic [HDR_BYTES-1:0][7:0]     hdr_b;

  assign cmd     = req.req_cmd;
  assign is_cfg  = (cmd.kind == CMD_CFG);
  assign is_64   = |cmd.addr[ADDR_W-1:32];                  // 4DW form only when needed
  assign addr_dw = {cmd.addr[ADDR_W-1:2], 2'b00};
  assign len_dw  = is_cfg ? LEN_W'(1) : cmd.len;
  assign be      = is_cfg ? 8'h0F : first_last_be(cmd.addr[1:0]);

  always_comb begin
    if (is_cfg) begin
      opcode = cmd.wr ? CFGWR0 : CFGRD0;
    end else if (is_64) begin
      opcode = cmd.wr ? MWR64 : MRD64;
    end else begin
      opcode = cmd.wr ? MWR32 : MRD32;
    end
  end

  // Byte 0 lands in hdr bits 7:0
  always_comb begin
    hdr_b    = '0;
    hdr_b[0] = opcode;
    hdr_b[2] = {6'b0, len_dw[9:8]};
    hdr_b[3] = len_dw[7:0];
    hdr_b[4] = requester_id_i[15:8];
    hdr_b[5] = requester_id_i[7:0];
    hdr_b[6] = req.req_tag;
    hdr_b[7] = be;

    if (is_cfg) begin
      hdr_b[8]  = cmd.bus;
      hdr_b[9]  = {cmd.dev, cmd.func};
      hdr_b[10] = {4'b0, cmd.reg_num[9:6]};
      hdr_b[11] = {cmd.reg_num[5:0], 2'b00};                // Register is DW aligned
    end else if (is_64) begin
      for (int i = 0; i < 8; i++) begin
        hdr_b[8+i] = addr_dw[ADDR_W-1-8*i -: 8];            // MSB first
      end
    end else begin
      for (int i = 0; i < 4; i++) begin
        hdr_b[8+i] = addr_dw[31-8*i -: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req.req_o_valid) begin
      hdr_o <= hdr_b;                                       // Held until the next request
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hdr_valid_o <= 1'b0;
    end else begin
      hdr_valid_o <= req.req_o_valid;
    end
  end

  // The sequencer passes through idle between requests
  a_valid_single: assert property (
    @(posedge clk) disable iff (!rst_n) hdr_valid_o |=> !hdr_valid_o
  ) else $error("hdr_valid_o high for two cycles");

endmodule

//--- hdl/tlp_cmd_sequencer.sv
`timescale 1ns/1ps

module tlp_cmd_sequencer
  import tlp_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,

  input  tlp_cmd_t          cmd_i,
  input  logic              cmd_valid_i,
  output logic              cmd_ready_o,

  input  logic [TAG_W-1:0]  tag_i,
  input  logic              tag_valid_i,
  output logic              tag_consume_o,

  input  logic              ph_credit_ok_i,
  input  logic              pd_credit_ok_i,
  input  logic              nph_credit_ok_i,
  input  logic              npd_credit_ok_i,
  input  logic              hdr_ready_i,

  tlp_req_if.seq            req
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_DECODE,
    S_WAIT_TAG,
    S_WAIT_CRED,
    S_DROP
  } seq_state_e;

  seq_state_e        state_q;
  seq_state_e        state_d;
  tlp_cmd_t          cmd_q;
  logic [TAG_W-1:0]  tag_q;
  logic              supported;
  logic              posted;
  logic              cred_ok;
  logic              grant;

  assign supported = (cmd_q.kind == CMD_MEM) || (cmd_q.kind == CMD_CFG);
  assign posted    = (cmd_q.kind == CMD_MEM) && cmd_q.wr;  // Only memory writes are posted

  // Credit class needed by the held request
  always_comb begin
    case (cmd_q.kind)
      CMD_MEM: cred_ok = cmd_q.wr ? (ph_credit_ok_i && pd_credit_ok_i) : nph_credit_ok_i;
      CMD_CFG: cred_ok = cmd_q.wr ? (nph_credit_ok_i && npd_credit_ok_i) : nph_credit_ok_i;
      default: cred_ok = 1'b0;
    endcase
  end

  assign grant         = (state_q == S_WAIT_CRED) && cred_ok && hdr_ready_i;
  assign cmd_ready_o   = (state_q == S_IDLE);
  assign tag_consume_o = (state_q == S_WAIT_TAG) && tag_valid_i;  // Same-cycle pulse

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE: begin
        if (cmd_valid_i) begin
          state_d = S_DECODE;
        end
      end
      S_DECODE: begin
        if (!supported) begin
          state_d = S_DROP;
        end else if (posted) begin
          state_d = S_WAIT_CRED;                            // No tag for posted writes
        end else begin
          state_d = S_WAIT_TAG;
        end
      end
      S_WAIT_TAG: begin
        if (tag_valid_i) begin
          state_d = S_WAIT_CRED;
        end
      end
      S_WAIT_CRED: begin
        if (grant) begin
          state_d = S_IDLE;
        end
      end
      S_DROP: begin
        state_d = S_IDLE;                                   // Command discarded silently
      end
      default: begin
        state_d = S_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= S_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Command and tag holding registers
  always_ff @(posedge clk) begin
    if (cmd_valid_i && cmd_ready_o) begin
      cmd_q <= cmd_i;
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == S_DECODE) begin
      tag_q <= '0;                                          // Stays zero for posted writes
    end else if (tag_consume_o) begin
      tag_q <= tag_i;
    end
  end

  assign req.req_o_valid = grant;
  assign req.req_cmd     = cmd_q;
  assign req.req_tag     = tag_q;

  a_consume_non_posted: assert property (
    @(posedge clk) disable iff (!rst_n) tag_consume_o |-> supported && !posted
  ) else $error("tag consumed for a posted or unsupported command");

  a_posted_tag_zero: assert property (
    @(posedge clk) disable iff (!rst_n) req.req_o_valid && posted |-> req.req_tag == '0
  ) else $error("posted request granted with a non-zero tag");

endmodule

//--- hdl/tlp_req_if.sv
`timescale 1ns/1ps

// Granted request passed from the sequencer to the formatter.
// Command and tag are only meaningful in the strobe cycle.
interface tlp_req_if
  import tlp_pkg::*;
();

  logic              req_o_valid;          // One-cycle strobe
  tlp_cmd_t          req_cmd;
  logic [TAG_W-1:0]  req_tag;

  modport seq (
    output req_o_valid,
    output req_cmd,
    output req_tag
  );

  modport fmt (
    input  req_o_valid,
    input  req_cmd,
    input  req_tag
  );

endinterface

//--- hdl/tlp_pkg.sv
package tlp_pkg;

  localparam int TAG_W     = 8;
  localparam int HDR_W     = 128;
  localparam int ADDR_W    = 64;
  localparam int LEN_W     = 10;
  localparam int RID_W     = 16;
  localparam int CFG_REG_W = 10;
  localparam int BUS_W     = 8;
  localparam int DEV_W     = 5;
  localparam int FUNC_W    = 3;

  localparam int HDR_BYTES = HDR_W / 8;

  // Command kinds from the user side
  typedef enum logic [1:0] {
    CMD_MEM = 2'd0,
    CMD_CFG = 2'd1,
    CMD_IO  = 2'd2,                        // Unsupported and dropped
    CMD_MSG = 2'd3                         // Unsupported and dropped
  } cmd_kind_e;

  // Fmt/Type byte of the header
  typedef enum logic [7:0] {
    MRD32  = 8'h00,
    MRD64  = 8'h20,
    MWR32  = 8'h40,
    MWR64  = 8'h60,
    CFGRD0 = 8'h04,
    CFGWR0 = 8'h44
  } fmt_type_e;

  typedef struct packed {
    cmd_kind_e              kind;
    logic                   wr;            // Write when set
    logic [ADDR_W-1:0]      addr;
    logic [LEN_W-1:0]       len;           // Length in doublewords
    logic [BUS_W-1:0]       bus;
    logic [DEV_W-1:0]       dev;
    logic [FUNC_W-1:0]      func;
    logic [CFG_REG_W-1:0]   reg_num;
  } tlp_cmd_t;

  // Last BE in the high nibble, first BE in the low nibble
  function automatic logic [7:0] first_last_be(input logic [1:0] addr_lo);
    logic [7:0] be;
    case (addr_lo)
      2'd0:    be = 8'hFF;
      2'd1:    be = 8'h1E;
      2'd2:    be = 8'h3C;
      default: be = 8'h78;
    endcase
    return be;
  endfunction

endpackage
